// ==== include/krv_dbg_defines.svh ====
//------------------------------
// debug trigger unit constants
// widths, trigger count, debug register numbers, tdata1 fields
//------------------------------

`ifndef KRV_DBG_DEFINES_SVH
`define KRV_DBG_DEFINES_SVH

// datapath
`define KRV_ADDR_WIDTH		32	// address and data width
`define KRV_NUM_TRIGGERS	2	// hardware triggers, 4 also supported

// debug register access port
`define KRV_REGNO_WIDTH		12
`define KRV_REG_TSELECT		12'h7a0
`define KRV_REG_TDATA1		12'h7a1
`define KRV_REG_TDATA2		12'h7a2

// tdata1 bit positions
`define KRV_TD1_LOAD		0
`define KRV_TD1_STORE		1
`define KRV_TD1_EXEC		2
`define KRV_TD1_MATCH_LO	7	// two-bit match field starts here

`endif

// ==== logic/krv_dbg_pkg.sv ====
//------------------------------
// debug trigger unit types
// shared by the RTL and the testbench
//------------------------------

`include "krv_dbg_defines.svh"

package krv_dbg_pkg;

	// value 1 is unused and compares as equal
	typedef enum logic [1:0] {
		MATCH_EQ = 2'd0,
		MATCH_GE = 2'd2,
		MATCH_LT = 2'd3
	} match_mode_e;

	typedef enum logic [2:0] {
		CAUSE_NONE    = 3'd0,
		CAUSE_EBREAK  = 3'd1,
		CAUSE_TRIGGER = 3'd2
	} dbg_cause_e;

	typedef logic [$clog2(`KRV_NUM_TRIGGERS)-1:0] trig_idx_t;	// trigger number

endpackage

// ==== logic/dbg_ifs.sv ====
//------------------------------
// trigger config and execute-stage
// observation interfaces
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

// one trigger's configuration, levels only
interface trig_cfg_if import krv_dbg_pkg::*; ();
	logic				exec_en;
	logic				load_en;
	logic				store_en;
	match_mode_e			match_mode;
	logic [`KRV_ADDR_WIDTH-1:0]	match_addr;

	modport source (
		output exec_en, load_en, store_en, match_mode, match_addr
	);

	modport sink (
		input  exec_en, load_en, store_en, match_mode, match_addr
	);
endinterface

// execute stage as seen by the triggers, no back-pressure
interface exec_obs_if;
	logic				ex_valid;	// one retiring instruction
	logic [`KRV_ADDR_WIDTH-1:0]	pc_ex;
	logic				load_ex;
	logic				store_ex;
	logic [`KRV_ADDR_WIDTH-1:0]	mem_addr_ex;

	modport observer (
		input  ex_valid, pc_ex, load_ex, store_ex, mem_addr_ex
	);
endinterface

// ==== logic/trigger_regs.sv ====
//------------------------------
// trigger registers
// tselect plus per-trigger tdata1/tdata2,
// reached through the debug register port
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module trigger_regs import krv_dbg_pkg::*; (
	input  logic				cpu_clk,
	input  logic				rst,
	input  logic				dbg_reg_access,
	input  logic				dbg_wr1_rd0,
	input  logic [`KRV_REGNO_WIDTH-1:0]	dbg_regno,
	input  logic [`KRV_ADDR_WIDTH-1:0]	dbg_write_data,
	output logic				dbg_read_data_valid,
	output logic [`KRV_ADDR_WIDTH-1:0]	dbg_read_data,
	trig_cfg_if.source			cfg [`KRV_NUM_TRIGGERS]
);

	trig_idx_t			tselect;
	logic				exec_en_q  [`KRV_NUM_TRIGGERS];
	logic				load_en_q  [`KRV_NUM_TRIGGERS];
	logic				store_en_q [`KRV_NUM_TRIGGERS];
	match_mode_e			match_q    [`KRV_NUM_TRIGGERS];
	logic [`KRV_ADDR_WIDTH-1:0]	tdata2_q   [`KRV_NUM_TRIGGERS];
	logic				wr_en;
	logic [`KRV_ADDR_WIDTH-1:0]	rd_word;

	assign wr_en = dbg_reg_access & dbg_wr1_rd0;

	// tselect and the tdata1 fields
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			tselect <= '0;
			for (int i = 0; i < `KRV_NUM_TRIGGERS; i++) begin
				exec_en_q[i]  <= 1'b0;
				load_en_q[i]  <= 1'b0;
				store_en_q[i] <= 1'b0;
				match_q[i]    <= MATCH_EQ;
			end
		end else if (wr_en) begin
			case (dbg_regno)
				`KRV_REG_TSELECT: begin
					if (dbg_write_data < `KRV_NUM_TRIGGERS)	// out of range dropped
						tselect <= trig_idx_t'(dbg_write_data);
				end
				`KRV_REG_TDATA1: begin
					exec_en_q[tselect]  <= dbg_write_data[`KRV_TD1_EXEC];
					load_en_q[tselect]  <= dbg_write_data[`KRV_TD1_LOAD];
					store_en_q[tselect] <= dbg_write_data[`KRV_TD1_STORE];
					match_q[tselect]    <=
						match_mode_e'(dbg_write_data[`KRV_TD1_MATCH_LO +: 2]);
				end
				default: ;
			endcase
		end
	end

	// match addresses
	always_ff @(posedge cpu_clk) begin
		if (wr_en && dbg_regno == `KRV_REG_TDATA2)
			tdata2_q[tselect] <= dbg_write_data;
	end

	// read mux on the selected trigger
	always_comb begin
		rd_word = '0;
		case (dbg_regno)
			`KRV_REG_TSELECT: rd_word[$bits(trig_idx_t)-1:0] = tselect;
			`KRV_REG_TDATA1: begin
				rd_word[`KRV_TD1_LOAD]           = load_en_q[tselect];
				rd_word[`KRV_TD1_STORE]          = store_en_q[tselect];
				rd_word[`KRV_TD1_EXEC]           = exec_en_q[tselect];
				rd_word[`KRV_TD1_MATCH_LO +: 2]  = match_q[tselect];
			end
			`KRV_REG_TDATA2: rd_word = tdata2_q[tselect];
			default: rd_word = '0;	// unknown regno reads zero
		endcase
	end

	// every access answers one cycle later
	always_ff @(posedge cpu_clk) begin
		if (rst)
			dbg_read_data_valid <= 1'b0;
		else
			dbg_read_data_valid <= dbg_reg_access;
	end

	always_ff @(posedge cpu_clk) begin
		if (dbg_reg_access)
			dbg_read_data <= dbg_wr1_rd0 ? '0 : rd_word;	// writes return zero
	end

	for (genvar g = 0; g < `KRV_NUM_TRIGGERS; g++) begin : g_cfg
		assign cfg[g].exec_en    = exec_en_q[g];
		assign cfg[g].load_en    = load_en_q[g];
		assign cfg[g].store_en   = store_en_q[g];
		assign cfg[g].match_mode = match_q[g];
		assign cfg[g].match_addr = tdata2_q[g];
	end

endmodule

// ==== logic/hw_trigger.sv ====
//------------------------------
// address-match trigger
// pc or load/store address, registered hit
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module hw_trigger import krv_dbg_pkg::*; (
	input  logic		cpu_clk,
	input  logic		rst,
	trig_cfg_if.sink	cfg,
	exec_obs_if.observer	obs,
	output logic		hit
);

	logic exec_match;
	logic load_match;
	logic store_match;

	// unsigned compare, unused mode falls back to equal
	function automatic logic addr_cmp(
		input match_mode_e			mode,
		input logic [`KRV_ADDR_WIDTH-1:0]	addr,
		input logic [`KRV_ADDR_WIDTH-1:0]	ref_addr
	);
		case (mode)
			MATCH_GE: return addr >= ref_addr;
			MATCH_LT: return addr <  ref_addr;
			default:  return addr == ref_addr;
		endcase
	endfunction

	assign exec_match  = cfg.exec_en & addr_cmp(cfg.match_mode, obs.pc_ex, cfg.match_addr);
	assign load_match  = cfg.load_en & obs.load_ex &
			     addr_cmp(cfg.match_mode, obs.mem_addr_ex, cfg.match_addr);
	assign store_match = cfg.store_en & obs.store_ex &
			     addr_cmp(cfg.match_mode, obs.mem_addr_ex, cfg.match_addr);

	always_ff @(posedge cpu_clk) begin
		if (rst)
			hit <= 1'b0;
		else
			hit <= obs.ex_valid & (exec_match | load_match | store_match);
	end

endmodule

// ==== logic/dbg_mode_ctrl.sv ====
//------------------------------
// debug mode controller
// entry on hit or ebreak, exit on dret
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module dbg_mode_ctrl import krv_dbg_pkg::*; (
	input  logic				cpu_clk,
	input  logic				rst,
	input  logic [`KRV_NUM_TRIGGERS-1:0]	hit,
	input  logic				ebreak,
	input  logic				dret,
	exec_obs_if.observer			obs,
	output logic				dbg_mode,
	output logic [`KRV_ADDR_WIDTH-1:0]	dpc,
	output dbg_cause_e			dbg_cause,
	output trig_idx_t			dbg_trigger
);

	logic [`KRV_ADDR_WIDTH-1:0]	pc_ex_q;	// pc of the instruction behind a hit
	trig_idx_t			hit_idx;

	always_ff @(posedge cpu_clk) begin
		pc_ex_q <= obs.pc_ex;
	end

	// lowest numbered trigger wins
	always_comb begin
		hit_idx = '0;
		for (int i = `KRV_NUM_TRIGGERS-1; i >= 0; i--) begin
			if (hit[i])
				hit_idx = trig_idx_t'(i);
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			dbg_mode    <= 1'b0;
			dpc         <= '0;
			dbg_cause   <= CAUSE_NONE;
			dbg_trigger <= '0;
		end else if (dbg_mode) begin
			if (dret)
				dbg_mode <= 1'b0;	// cause and dpc kept
		end else if (|hit) begin	// older instruction beats ebreak
			dbg_mode    <= 1'b1;
			dpc         <= pc_ex_q;
			dbg_cause   <= CAUSE_TRIGGER;
			dbg_trigger <= hit_idx;
		end else if (ebreak && obs.ex_valid) begin
			dbg_mode  <= 1'b1;
			dpc       <= obs.pc_ex;
			dbg_cause <= CAUSE_EBREAK;
		end
	end

endmodule

// ==== logic/dbg_trigger_unit.sv ====
//------------------------------
// debug trigger unit top
// registers, hardware triggers, debug mode
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module dbg_trigger_unit import krv_dbg_pkg::*; (
	input  logic				cpu_clk,
	input  logic				rst,
	// execute stage
	input  logic				ex_valid,
	input  logic [`KRV_ADDR_WIDTH-1:0]	pc_ex,
	input  logic				load_ex,
	input  logic				store_ex,
	input  logic [`KRV_ADDR_WIDTH-1:0]	mem_addr_ex,
	input  logic				ebreak,
	input  logic				dret,
	// debug register access
	input  logic				dbg_reg_access,
	input  logic				dbg_wr1_rd0,	// 1 write, 0 read
	input  logic [`KRV_REGNO_WIDTH-1:0]	dbg_regno,
	input  logic [`KRV_ADDR_WIDTH-1:0]	dbg_write_data,
	output logic				dbg_read_data_valid,
	output logic [`KRV_ADDR_WIDTH-1:0]	dbg_read_data,
	// debug state
	output logic				dbg_mode,
	output logic [`KRV_ADDR_WIDTH-1:0]	dpc,
	output dbg_cause_e			dbg_cause,
	output trig_idx_t			dbg_trigger
);

	logic [`KRV_NUM_TRIGGERS-1:0] hit;

	exec_obs_if u_obs ();
	trig_cfg_if u_cfg [`KRV_NUM_TRIGGERS] ();

	assign u_obs.ex_valid    = ex_valid;
	assign u_obs.pc_ex       = pc_ex;
	assign u_obs.load_ex     = load_ex;
	assign u_obs.store_ex    = store_ex;
	assign u_obs.mem_addr_ex = mem_addr_ex;

	trigger_regs u_trigger_regs (
		.cpu_clk		(cpu_clk),
		.rst			(rst),
		.dbg_reg_access		(dbg_reg_access),
		.dbg_wr1_rd0		(dbg_wr1_rd0),
		.dbg_regno		(dbg_regno),
		.dbg_write_data		(dbg_write_data),
		.dbg_read_data_valid	(dbg_read_data_valid),
		.dbg_read_data		(dbg_read_data),
		.cfg			(u_cfg)
	);

	for (genvar g = 0; g < `KRV_NUM_TRIGGERS; g++) begin : g_trig
		hw_trigger u_hw_trigger (
			.cpu_clk	(cpu_clk),
			.rst		(rst),
			.cfg		(u_cfg[g]),
			.obs		(u_obs),
			.hit		(hit[g])
		);
	end

	dbg_mode_ctrl u_dbg_mode_ctrl (
		.cpu_clk	(cpu_clk),
		.rst		(rst),
		.hit		(hit),
		.ebreak		(ebreak),
		.dret		(dret),
		.obs		(u_obs),
		.dbg_mode	(dbg_mode),
		.dpc		(dpc),
		.dbg_cause	(dbg_cause),
		.dbg_trigger	(dbg_trigger)
	);

endmodule

// ==== testbench/dbg_trigger_props.sv ====
//------------------------------
// debug trigger unit properties
// bound into the top level
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module dbg_trigger_props (
	input logic				cpu_clk,
	input logic				rst,
	input logic				dbg_reg_access,
	input logic				dbg_read_data_valid,
	input logic				ex_valid,
	input logic				ebreak,
	input logic				dret,
	input logic				dbg_mode,
	input logic [`KRV_NUM_TRIGGERS-1:0]	hit
);

	int fail_count = 0;	// failed assertions so far

	// one valid pulse per access
	a_read_valid: assert property (@(posedge cpu_clk) disable iff (rst)
		dbg_read_data_valid == $past(dbg_reg_access))
		else begin
			$error("read valid does not follow register access by one cycle");
			fail_count++;
		end

	// hit is already one cycle behind its execute cycle
	a_entry: assert property (@(posedge cpu_clk) disable iff (rst)
		$rose(dbg_mode) |-> $past(ebreak && ex_valid) || $past(|hit))
		else begin
			$error("debug mode entered without ebreak or trigger hit");
			fail_count++;
		end

	a_exit: assert property (@(posedge cpu_clk) disable iff (rst)
		dbg_mode && dret |=> !dbg_mode)
		else begin
			$error("dret did not leave debug mode");
			fail_count++;
		end

endmodule

// ==== testbench/tb_dbg_trigger_unit.sv ====
//------------------------------
// debug trigger unit testbench
// lfsr stimulus checked against
// a cycle model of the unit
//------------------------------

`timescale 1ns/1ns

`include "krv_dbg_defines.svh"

module tb_dbg_trigger_unit import krv_dbg_pkg::*; ();

	localparam int NUM_TRIG      = `KRV_NUM_TRIGGERS;
	localparam int RESET_CYCLES  = 10;
	localparam int SETUP_CYCLES  = 2 * NUM_TRIG + 5;
	localparam int RANDOM_CYCLES = 1500;
	localparam int CYCLE_LIMIT   = 2 * (RESET_CYCLES + SETUP_CYCLES + RANDOM_CYCLES);

	logic				cpu_clk;
	logic				rst;
	logic				ex_valid;
	logic [`KRV_ADDR_WIDTH-1:0]	pc_ex;
	logic				load_ex;
	logic				store_ex;
	logic [`KRV_ADDR_WIDTH-1:0]	mem_addr_ex;
	logic				ebreak;
	logic				dret;
	logic				dbg_reg_access;
	logic				dbg_wr1_rd0;
	logic [`KRV_REGNO_WIDTH-1:0]	dbg_regno;
	logic [`KRV_ADDR_WIDTH-1:0]	dbg_write_data;
	logic				dbg_read_data_valid;
	logic [`KRV_ADDR_WIDTH-1:0]	dbg_read_data;
	logic				dbg_mode;
	logic [`KRV_ADDR_WIDTH-1:0]	dpc;
	dbg_cause_e			dbg_cause;
	trig_idx_t			dbg_trigger;

	// reference model state
	int				m_tselect;
	logic				m_exec  [NUM_TRIG];
	logic				m_load  [NUM_TRIG];
	logic				m_store [NUM_TRIG];
	logic [1:0]			m_match [NUM_TRIG];
	logic [31:0]			m_tdata2 [NUM_TRIG];
	logic [NUM_TRIG-1:0]		m_hit;
	logic				m_rvalid;
	logic [31:0]			m_rdata;
	logic				m_mode;
	logic [31:0]			m_dpc;
	logic [31:0]			m_pc_q;
	dbg_cause_e			m_cause;
	trig_idx_t			m_trig;

	logic [15:0]			lfsr_state = 16'd22069;
	int				errors = 0;
	int				checks = 0;
	int				cycle_count = 0;

	dbg_trigger_unit u_dut (.*);

	bind dbg_trigger_unit dbg_trigger_props u_props (.*);

	// x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// small pool so matches come often
	function automatic logic [31:0] pool_addr(input logic [31:0] k);
		case (k[1:0])
			2'd0: return 32'h0000_1000;
			2'd1: return 32'h0000_1004;
			2'd2: return 32'h0000_1008;
			default: return 32'h0000_2000;
		endcase
	endfunction

	// 2 is >=, 3 is <, anything else is ==
	function automatic logic addr_hits(input logic [1:0] mode, input logic [31:0] a,
			input logic [31:0] ref_addr);
		logic below;
		below = a < ref_addr;
		if (mode == 2'd2)
			return !below;
		if (mode == 2'd3)
			return below;
		return a == ref_addr;
	endfunction

	function automatic logic trig_fires(input int i);
		logic pc_ok;
		logic mem_ok;
		pc_ok  = addr_hits(m_match[i], pc_ex, m_tdata2[i]);
		mem_ok = addr_hits(m_match[i], mem_addr_ex, m_tdata2[i]);
		return ex_valid && ((m_exec[i] && pc_ok) ||
			(mem_ok && ((m_load[i] && load_ex) || (m_store[i] && store_ex))));
	endfunction

	// model state after one rising edge
	function automatic void model_step();
		int first;
		int sel;
		first = -1;
		sel = m_tselect;
		if (rst) begin
			m_tselect = 0;
			m_hit     = '0;
			m_rvalid  = 1'b0;
			m_mode    = 1'b0;
			m_dpc     = '0;
			m_cause   = CAUSE_NONE;
			m_trig    = '0;
			for (int i = 0; i < NUM_TRIG; i++) begin
				m_exec[i]  = 1'b0;
				m_load[i]  = 1'b0;
				m_store[i] = 1'b0;
				m_match[i] = 2'd0;
			end
		end else begin
			for (int i = NUM_TRIG - 1; i >= 0; i--) begin
				if (m_hit[i])
					first = i;	// lowest number wins
			end
			if (m_mode) begin
				if (dret)
					m_mode = 1'b0;
			end else if (first >= 0) begin
				m_mode  = 1'b1;
				m_dpc   = m_pc_q;	// hit belongs to last cycle's pc
				m_cause = CAUSE_TRIGGER;
				m_trig  = trig_idx_t'(first);
			end else if (ebreak && ex_valid) begin
				m_mode  = 1'b1;
				m_dpc   = pc_ex;
				m_cause = CAUSE_EBREAK;
			end
			for (int i = 0; i < NUM_TRIG; i++)
				m_hit[i] = trig_fires(i);
			m_rvalid = dbg_reg_access;
			if (dbg_reg_access && !dbg_wr1_rd0) begin
				case (dbg_regno)
					`KRV_REG_TSELECT: m_rdata = m_tselect;
					`KRV_REG_TDATA1: m_rdata = {23'd0, m_match[sel], 4'd0,
						m_exec[sel], m_store[sel], m_load[sel]};
					`KRV_REG_TDATA2: m_rdata = m_tdata2[sel];
					default: m_rdata = '0;
				endcase
			end else if (dbg_reg_access) begin
				m_rdata = '0;
				case (dbg_regno)
					`KRV_REG_TSELECT: begin
						if (dbg_write_data < NUM_TRIG)
							m_tselect = int'(dbg_write_data);
					end
					`KRV_REG_TDATA1: begin
						m_load[sel]  = dbg_write_data[0];
						m_store[sel] = dbg_write_data[1];
						m_exec[sel]  = dbg_write_data[2];
						m_match[sel] = dbg_write_data[8:7];
					end
					`KRV_REG_TDATA2: m_tdata2[sel] = dbg_write_data;
					default: ;
				endcase
			end
		end
		m_pc_q = pc_ex;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// model follows the edge, outputs compared 1 ns later, inputs free at 2 ns
	task automatic tick();
		@(posedge cpu_clk);
		model_step();
		#1;
		check_value("read valid", dbg_read_data_valid, m_rvalid);
		if (m_rvalid)
			check_value("read data", dbg_read_data, m_rdata);
		check_value("dbg_mode", dbg_mode, m_mode);
		check_value("dpc", dpc, m_dpc);
		check_value("dbg_cause", dbg_cause, m_cause);
		check_value("dbg_trigger", dbg_trigger, m_trig);
		#1;
	endtask

	task automatic reg_write(input logic [11:0] regno, input logic [31:0] data);
		dbg_reg_access = 1'b1;
		dbg_wr1_rd0    = 1'b1;
		dbg_regno      = regno;
		dbg_write_data = data;
		tick();
		dbg_reg_access = 1'b0;
	endtask

	task automatic read_expect(input logic [11:0] regno, input logic [31:0] exp);
		dbg_reg_access = 1'b1;
		dbg_wr1_rd0    = 1'b0;
		dbg_regno      = regno;
		tick();
		check_value("readback valid", dbg_read_data_valid, 1);
		check_value("readback", dbg_read_data, exp);
		dbg_reg_access = 1'b0;
	endtask

	task automatic drive_random();
		logic [31:0] kind;
		ex_valid       = rand_bits(2) != 0;
		pc_ex          = pool_addr(rand_bits(2));
		load_ex        = rand_bits(1) != 0;
		store_ex       = !load_ex && rand_bits(1) != 0;
		mem_addr_ex    = pool_addr(rand_bits(2));
		ebreak         = rand_bits(3) == 0;
		dret           = rand_bits(2) == 0;
		dbg_reg_access = rand_bits(3) == 0;
		dbg_wr1_rd0    = rand_bits(1) != 0;
		kind           = rand_bits(2);
		dbg_regno      = `KRV_REG_TSELECT + 12'(kind);	// 0x7a3 is unknown
		if (kind == 0)
			dbg_write_data = rand_bits(2);	// half of these out of range
		else if (kind == 2)
			dbg_write_data = pool_addr(rand_bits(2));
		else
			dbg_write_data = rand_bits(9);
	endtask

	initial begin
		cpu_clk = 1'b0;
		forever #10 cpu_clk = ~cpu_clk;
	end

	// hard stop
	initial begin
		while (cycle_count <= CYCLE_LIMIT) begin
			@(posedge cpu_clk);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst            = 1'b1;
		ex_valid       = 1'b0;
		pc_ex          = '0;
		load_ex        = 1'b0;
		store_ex       = 1'b0;
		mem_addr_ex    = '0;
		ebreak         = 1'b0;
		dret           = 1'b0;
		dbg_reg_access = 1'b0;
		dbg_wr1_rd0    = 1'b0;
		dbg_regno      = '0;
		dbg_write_data = '0;
		repeat (RESET_CYCLES) tick();
		rst = 1'b0;
		// give every trigger a match address before any read
		for (int t = 0; t < NUM_TRIG; t++) begin
			reg_write(`KRV_REG_TSELECT, t);
			reg_write(`KRV_REG_TDATA2, pool_addr(t));
		end
		reg_write(`KRV_REG_TDATA1, 32'hffff_ffff);
		read_expect(`KRV_REG_TDATA1, 32'h0000_0187);	// only defined fields kept
		reg_write(`KRV_REG_TSELECT, NUM_TRIG);
		read_expect(`KRV_REG_TSELECT, NUM_TRIG - 1);
		read_expect(12'h7ff, '0);
		repeat (RANDOM_CYCLES) begin
			drive_random();
			tick();
		end
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_dut.u_props.fail_count);
		if (errors == 0 && u_dut.u_props.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
logic/krv_dbg_pkg.sv
logic/dbg_ifs.sv
logic/trigger_regs.sv
logic/hw_trigger.sv
logic/dbg_mode_ctrl.sv
logic/dbg_trigger_unit.sv
testbench/dbg_trigger_props.sv
testbench/tb_dbg_trigger_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug trigger unit testbench with Verilator.
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_dbg_trigger_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dbg_trigger_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
	exit 0
fi
exit 1
